//--- all.f
+incdir+.
epd_pkg.sv
csr_pkg.sv
spi_csr.sv
pixel_update.sv
source_driver.sv
caster.sv
tb_caster.sv

//--- tb_spi_host.svh
`ifndef TB_SPI_HOST_SVH
`define TB_SPI_HOST_SVH

// sck half period in clk cycles, the DUT needs at least 4
localparam int SPI_HALF = 5;

task automatic spi_pause(input int cycles);
    repeat (cycles) @(posedge clk);
    #DRIVE_DELAY;
endtask

// One mode 0 frame, MSB first
// miso is taken at each rising sck of the data bits
task automatic spi_frame(input logic [`CASTER_SPI_FRAME_BITS-1:0] tx,
                         output csr_pkg::reg_data_t rx);
    rx = '0;
    spi_cs = 1'b0;
    spi_pause(SPI_HALF);
    for (int i = `CASTER_SPI_FRAME_BITS - 1; i >= 0; i--) begin
        spi_mosi = tx[i];
        spi_pause(SPI_HALF);
        spi_sck = 1'b1;
        if (i < `CASTER_SPI_DATA_BITS) begin
            rx = {rx[`CASTER_SPI_DATA_BITS-2:0], spi_miso};
        end
        spi_pause(SPI_HALF);
        spi_sck = 1'b0;
    end
    spi_pause(SPI_HALF);
    spi_cs = 1'b1;
    spi_pause(2 * SPI_HALF);
endtask

task automatic spi_write(input csr_pkg::reg_addr_t addr, input csr_pkg::reg_data_t data);
    csr_pkg::reg_data_t unused;
    spi_frame({1'b0, addr, data}, unused);
endtask

// Data bits of a read frame are don't care on mosi
task automatic spi_read(input csr_pkg::reg_addr_t addr, output csr_pkg::reg_data_t data);
    spi_frame({1'b1, addr, 8'h00}, data);
endtask

`endif

//--- tb_caster.sv
`include "caster_settings.svh"

module tb_caster;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRIVE_DELAY = 10;
    localparam int DIR_LEN = 8;
    localparam int TAB_LEN = 32;
    localparam int LINE = `CASTER_LINE_WORDS;
    localparam int WATCHDOG_CYCLES = TAB_LEN * 20 + 2000;

    logic clk, rst;
    logic spi_cs, spi_sck, spi_mosi, spi_miso, sys_ready;
    logic vin_valid, vin_ready, bi_valid, bi_ready, bo_valid;
    logic epd_sdclk, epd_sdle, b_trigger;
    epd_pkg::pix_word_t vin_pixel, bi_pixel, bo_pixel;
    epd_pkg::drive_word_t epd_sd;

    // Table of target, state, expected drive and expected next state
    epd_pkg::pix_word_t tgt_tab [TAB_LEN];
    epd_pkg::pix_word_t st_tab [TAB_LEN];
    epd_pkg::drive_word_t drv_tab [TAB_LEN];
    epd_pkg::pix_word_t nxt_tab [TAB_LEN];

    int seed = 32'h85e46458;
    int errors = 0;
    int test_num = 0;
    int test_errs = 0;
    int tests_failed = 0;
    string test_name;
    int cyc = 0;
    int out_idx = 0;
    int trig_cycles = 0;
    int take_q [$];
    logic en_exp = 1'b0;

    caster i_dut (.*);

    `include "tb_spi_host.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s expected %0h got %0h", name, exp, act);
        errors++;
    endtask

    task automatic note_error(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        test_errs = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errs) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, test_name, errors - test_errs);
            tests_failed++;
        end
    endtask

    // Each pixel moves one grey level toward its target
    function automatic void step_rule(input logic [15:0] tgt, input logic [15:0] cur,
                                      output logic [7:0] drv, output logic [15:0] nxt);
        logic [3:0] t;
        logic [3:0] c;
        drv = 8'h00;
        nxt = cur;
        for (int p = 0; p < 4; p++) begin
            t = tgt[4*p +: 4];
            c = cur[4*p +: 4];
            if (t > c) begin
                drv[2*p +: 2] = epd_pkg::DRIVE_LIGHTEN;
                nxt[4*p +: 4] = c + 4'd1;
            end else if (t < c) begin
                drv[2*p +: 2] = epd_pkg::DRIVE_DARKEN;
                nxt[4*p +: 4] = c - 4'd1;
            end
        end
    endfunction

    task automatic put_entry(input int i, input logic [15:0] tgt, input logic [15:0] st,
                             input logic [7:0] drv, input logic [15:0] nxt);
        tgt_tab[i] = tgt;
        st_tab[i] = st;
        drv_tab[i] = drv;
        nxt_tab[i] = nxt;
    endtask

    task automatic load_table();
        logic [7:0] drv;
        logic [15:0] nxt;
        put_entry(0, 16'h0000, 16'h0000, 8'h00, 16'h0000);
        put_entry(1, 16'hffff, 16'h0000, 8'haa, 16'h1111);
        put_entry(2, 16'h0000, 16'hffff, 8'h55, 16'heeee);
        put_entry(3, 16'h5a3c, 16'h5b2c, 8'h18, 16'h5a3c);
        put_entry(4, 16'h0f80, 16'hf07f, 8'h69, 16'he18e);
        put_entry(5, 16'h1234, 16'h1234, 8'h00, 16'h1234);
        put_entry(6, 16'h8888, 16'h7999, 8'h95, 16'h8888);
        put_entry(7, 16'he001, 16'hf100, 8'h52, 16'he001);
        for (int i = DIR_LEN; i < TAB_LEN; i++) begin
            tgt_tab[i] = 16'($random(seed));
            st_tab[i] = 16'($random(seed));
            step_rule(tgt_tab[i], st_tab[i], drv, nxt);
            drv_tab[i] = drv;
            nxt_tab[i] = nxt;
        end
    endtask

    // Mode 0 keeps both valid, 1 toggles them at random, 2 offers one stream at a time first
    task automatic send_word(input int idx, input int mode);
        int tries;
        int r;
        logic taken;
        logic rdy_exp;
        tries = 0;
        taken = 1'b0;
        vin_pixel = tgt_tab[idx];
        bi_pixel = st_tab[idx];
        while (!taken) begin
            r = $random(seed);
            vin_valid = 1'b1;
            bi_valid = 1'b1;
            if (mode == 1 && tries < 16) begin
                vin_valid = r[0];
                bi_valid = r[1];
            end else if (mode == 2 && tries < 4) begin
                vin_valid = (tries < 2);
                bi_valid = (tries >= 2);
            end
            @(negedge clk);
            rdy_exp = en_exp && vin_valid && bi_valid;
            if (vin_ready !== rdy_exp) value_error("vin_ready", rdy_exp, vin_ready);
            if (bi_ready !== rdy_exp) value_error("bi_ready", rdy_exp, bi_ready);
            taken = vin_ready && bi_ready;
            if (taken) take_q.push_back(cyc);
            tries++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        vin_valid = 1'b0;
        bi_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (take_q.size() != 0 && n < 10) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        if (take_q.size() != 0) note_error("words taken but never written back");
    endtask

    // Write-back and source bus checked against the table in take order
    always @(negedge clk) begin : out_monitor
        int take_cyc;
        if (!rst) begin
            if (b_trigger) trig_cycles++;
            if (bo_valid) begin
                if (take_q.size() == 0) begin
                    note_error("bo_valid seen with no word taken");
                end else begin
                    take_cyc = take_q.pop_front();
                    if (cyc != take_cyc + 2) note_error("write-back not 2 cycles after take");
                    if (bo_pixel !== nxt_tab[out_idx]) begin
                        value_error("bo_pixel", nxt_tab[out_idx], bo_pixel);
                    end
                    if (epd_sd !== drv_tab[out_idx]) begin
                        value_error("epd_sd", drv_tab[out_idx], epd_sd);
                    end
                    if (epd_sdle !== (out_idx % LINE == LINE - 1)) begin
                        value_error("epd_sdle", out_idx % LINE == LINE - 1, epd_sdle);
                    end
                    out_idx++;
                end
                if (epd_sdclk !== 1'b1) value_error("epd_sdclk", 1, epd_sdclk);
            end else if (epd_sdclk !== 1'b0 || epd_sdle !== 1'b0) begin
                note_error("source strobe without a write-back word");
            end
        end
    end

    initial begin : run_tests
        csr_pkg::reg_data_t rd;
        rst = 1'b1;
        spi_cs = 1'b1;
        spi_sck = 1'b0;
        spi_mosi = 1'b0;
        sys_ready = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b0;
        bi_pixel = '0;
        bi_valid = 1'b0;
        load_table();
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        start_test("ctrl and status registers");
        spi_read(csr_pkg::ADDR_CTRL, rd);
        if (rd !== 8'h00) value_error("ctrl", 8'h00, rd);
        spi_write(csr_pkg::ADDR_CTRL, 8'h01);
        spi_read(csr_pkg::ADDR_CTRL, rd);
        if (rd !== 8'h01) value_error("ctrl", 8'h01, rd);
        sys_ready = 1'b1;
        spi_read(csr_pkg::ADDR_STATUS, rd);
        if (rd !== 8'h01) value_error("status", 8'h01, rd);
        sys_ready = 1'b0;
        spi_read(csr_pkg::ADDR_STATUS, rd);
        if (rd !== 8'h00) value_error("status", 8'h00, rd);
        finish_test();

        start_test("trigger pulse");
        if (trig_cycles != 0) note_error("b_trigger pulsed without a trigger write");
        spi_write(csr_pkg::ADDR_TRIGGER, 8'h5a);
        if (trig_cycles != 1) value_error("b_trigger cycles", 1, trig_cycles);
        spi_read(csr_pkg::ADDR_TRIGGER, rd);
        if (rd !== 8'h00) value_error("trigger", 8'h00, rd);
        if (trig_cycles != 1) value_error("b_trigger cycles", 1, trig_cycles);
        finish_test();

        start_test("streams held while disabled");
        spi_write(csr_pkg::ADDR_CTRL, 8'h00);
        en_exp = 1'b0;
        vin_pixel = tgt_tab[0];
        bi_pixel = st_tab[0];
        vin_valid = 1'b1;
        bi_valid = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (vin_ready !== 1'b0) value_error("vin_ready", 0, vin_ready);
            if (bi_ready !== 1'b0) value_error("bi_ready", 0, bi_ready);
            if (bo_valid !== 1'b0) value_error("bo_valid", 0, bo_valid);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        vin_valid = 1'b0;
        bi_valid = 1'b0;
        finish_test();

        start_test("continuous stream");
        spi_write(csr_pkg::ADDR_CTRL, 8'h01);
        en_exp = 1'b1;
        for (int i = 0; i < 16; i++) send_word(i, 0);
        wait_drain();
        finish_test();

        start_test("random stalls");
        for (int i = 16; i < 28; i++) send_word(i, 1);
        wait_drain();
        finish_test();

        start_test("single stream valid");
        for (int i = 28; i < TAB_LEN; i++) send_word(i, 2);
        wait_drain();
        if (out_idx != TAB_LEN) value_error("words written back", TAB_LEN, out_idx);
        finish_test();

        $display("%0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- caster.sv
module caster (
    input  logic                 clk,
    input  logic                 rst,
    // SPI register access
    input  logic                 spi_cs,
    input  logic                 spi_sck,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    input  logic                 sys_ready,
    // Target pixels from video input
    input  epd_pkg::pix_word_t   vin_pixel,
    input  logic                 vin_valid,
    output logic                 vin_ready,
    // Current pixel states from framebuffer
    input  epd_pkg::pix_word_t   bi_pixel,
    input  logic                 bi_valid,
    output logic                 bi_ready,
    // Write-back, no back-pressure
    output epd_pkg::pix_word_t   bo_pixel,
    output logic                 bo_valid,
    // Source driver
    output epd_pkg::drive_word_t epd_sd,
    output logic                 epd_sdclk,
    output logic                 epd_sdle,
    // Frame trigger
    output logic                 b_trigger
);

    logic global_en;
    logic take;
    logic result_valid;
    epd_pkg::drive_word_t drive;
    epd_pkg::pix_word_t next_state;

    spi_csr spi_csr (
        .clk(clk),
        .rst(rst),
        .spi_cs(spi_cs),
        .spi_sck(spi_sck),
        .spi_mosi(spi_mosi),
        .sys_ready(sys_ready),
        .spi_miso(spi_miso),
        .global_en(global_en),
        .b_trigger(b_trigger)
    );

    pixel_update pixel_update (
        .clk(clk),
        .rst(rst),
        .take(take),
        .target(vin_pixel),
        .state(bi_pixel),
        .drive(drive),
        .next_state(next_state),
        .result_valid(result_valid)
    );

    source_driver source_driver (
        .clk(clk),
        .rst(rst),
        .global_en(global_en),
        .vin_valid(vin_valid),
        .bi_valid(bi_valid),
        .vin_ready(vin_ready),
        .bi_ready(bi_ready),
        .take(take),
        .result_valid(result_valid),
        .drive(drive),
        .next_state(next_state),
        .epd_sd(epd_sd),
        .epd_sdclk(epd_sdclk),
        .epd_sdle(epd_sdle),
        .bo_pixel(bo_pixel),
        .bo_valid(bo_valid)
    );

endmodule

//--- source_driver.sv
`include "caster_settings.svh"

module source_driver (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 global_en,
    input  logic                 vin_valid,
    input  logic                 bi_valid,
    output logic                 vin_ready,
    output logic                 bi_ready,
    output logic                 take,
    input  logic                 result_valid,
    input  epd_pkg::drive_word_t drive,
    input  epd_pkg::pix_word_t   next_state,
    output epd_pkg::drive_word_t epd_sd,
    output logic                 epd_sdclk,
    output logic                 epd_sdle,
    output epd_pkg::pix_word_t   bo_pixel,
    output logic                 bo_valid
);

    localparam int CNT_BITS = (`CASTER_LINE_WORDS > 1) ? $clog2(`CASTER_LINE_WORDS) : 1;
    localparam logic [CNT_BITS-1:0] LAST_WORD = CNT_BITS'(`CASTER_LINE_WORDS - 1);

    // Position of the next output word within the source line
    logic [CNT_BITS-1:0] word_cnt;
    logic line_end;

    // Both streams move together or not at all
    assign take = global_en && vin_valid && bi_valid;
    assign vin_ready = take;
    assign bi_ready = take;

    assign line_end = (word_cnt == LAST_WORD);

    // Strobes follow the update stage by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            epd_sdclk <= 1'b0;
            epd_sdle <= 1'b0;
            bo_valid <= 1'b0;
            word_cnt <= '0;
        end else begin
            epd_sdclk <= result_valid;
            bo_valid <= result_valid;
            // Latch the line with its last word
            epd_sdle <= result_valid && line_end;
            if (result_valid) begin
                word_cnt <= line_end ? '0 : word_cnt + 1'b1;
            end
        end
    end

    // Source bus and write-back data hold between words
    always_ff @(posedge clk) begin
        if (result_valid) begin
            epd_sd <= drive;
            bo_pixel <= next_state;
        end
    end

    // Readies go high as a pair and the update stage holds that pair next cycle
    a_ready_pair: assert property (@(posedge clk) disable iff (rst)
        (vin_ready == bi_ready) && (result_valid == $past(vin_ready && bi_ready)));

    // Every taken word shows up two cycles later through pixel_update
    a_take_latency: assert property (@(posedge clk) disable iff (rst)
        take |-> ##2 (bo_valid && epd_sdclk));

endmodule

//--- pixel_update.sv
`include "caster_settings.svh"

module pixel_update (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 take,
    input  epd_pkg::pix_word_t   target,
    input  epd_pkg::pix_word_t   state,
    output epd_pkg::drive_word_t drive,
    output epd_pkg::pix_word_t   next_state,
    output logic                 result_valid
);

    localparam int PB = `CASTER_PIX_BITS;
    localparam int DB = `CASTER_DRIVE_BITS;

    epd_pkg::drive_word_t drive_calc;
    epd_pkg::pix_word_t state_calc;

    // One grey step toward the target, per pixel
    always_comb begin : step_calc
        epd_pkg::grey_t tgt;
        epd_pkg::grey_t cur;
        epd_pkg::grey_t nxt;
        epd_pkg::drive_t code;
        drive_calc = '0;
        state_calc = '0;
        for (int i = 0; i < `CASTER_PIX_PER_WORD; i++) begin
            tgt = target[i*PB +: PB];
            cur = state[i*PB +: PB];
            if (tgt > cur) begin
                code = epd_pkg::DRIVE_LIGHTEN;
                nxt = cur + 1'b1;
            end else if (tgt < cur) begin
                code = epd_pkg::DRIVE_DARKEN;
                nxt = cur - 1'b1;
            end else begin
                code = epd_pkg::DRIVE_NONE;
                nxt = cur;
            end
            drive_calc[i*DB +: DB] = code;
            state_calc[i*PB +: PB] = nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            drive <= drive_calc;
            next_state <= state_calc;
        end
    end

    function automatic logic within_one(epd_pkg::grey_t a, epd_pkg::grey_t b);
        int diff;
        diff = int'(a) - int'(b);
        return (diff >= -1) && (diff <= 1);
    endfunction

    // New state never jumps more than one grey level, no wrap either
    for (genvar p = 0; p < `CASTER_PIX_PER_WORD; p++) begin : g_step_chk
        a_one_step: assert property (@(posedge clk) disable iff (rst)
            result_valid |-> within_one(next_state[p*PB +: PB], $past(state[p*PB +: PB])));
    end

endmodule

//--- spi_csr.sv
`include "caster_settings.svh"

module spi_csr (
    input  logic clk,
    input  logic rst,
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic sys_ready,
    output logic spi_miso,
    output logic global_en,
    output logic b_trigger
);

    localparam int FRAME_BITS = `CASTER_SPI_FRAME_BITS;
    localparam int ADDR_BITS = `CASTER_SPI_ADDR_BITS;
    localparam int DATA_BITS = `CASTER_SPI_DATA_BITS;
    localparam int HDR_BITS = 1 + ADDR_BITS;
    localparam int CNT_BITS = $clog2(FRAME_BITS);
    localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(FRAME_BITS - 1);
    localparam logic [CNT_BITS-1:0] HDR_LAST = CNT_BITS'(HDR_BITS - 1);
    localparam logic [CNT_BITS-1:0] DATA_FIRST = CNT_BITS'(HDR_BITS);

    // Pin synchronizers with bit 1 as the safe copy
    logic [1:0] cs_sync;
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic sck_last;

    logic cs_act;
    logic sck_rise;
    logic sck_fall;
    logic hdr_done;
    logic frame_done;
    logic tx_step;

    logic [CNT_BITS-1:0] bit_cnt;
    logic [FRAME_BITS-2:0] rx_shift;
    logic [FRAME_BITS-1:0] frame;
    logic [HDR_BITS-1:0] header;
    csr_pkg::reg_addr_t rd_addr;
    csr_pkg::reg_addr_t wr_addr;
    csr_pkg::reg_data_t wr_data;
    csr_pkg::reg_data_t rd_data;
    csr_pkg::reg_data_t tx_shift;
    logic [1:0] trig_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync <= 2'b11;
            sck_sync <= 2'b00;
            sck_last <= 1'b0;
        end else begin
            cs_sync <= {cs_sync[0], spi_cs};
            sck_sync <= {sck_sync[0], spi_sck};
            sck_last <= sck_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
    end

    // cs is active low
    assign cs_act = !cs_sync[1];
    assign sck_rise = cs_act && sck_sync[1] && !sck_last;
    assign sck_fall = cs_act && !sck_sync[1] && sck_last;

    // Header and frame including the bit being sampled now
    assign header = {rx_shift[HDR_BITS-2:0], mosi_sync[1]};
    assign frame = {rx_shift, mosi_sync[1]};
    assign rd_addr = header[ADDR_BITS-1:0];
    assign wr_addr = frame[FRAME_BITS-2 -: ADDR_BITS];
    assign wr_data = frame[DATA_BITS-1:0];

    assign hdr_done = sck_rise && (bit_cnt == HDR_LAST);
    assign frame_done = sck_rise && (bit_cnt == LAST_BIT);
    assign tx_step = sck_fall && (bit_cnt >= DATA_FIRST);

    // A short frame is dropped when cs rises
    always_ff @(posedge clk) begin
        if (rst || !cs_act) begin
            bit_cnt <= '0;
        end else if (sck_rise) begin
            bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[FRAME_BITS-3:0], mosi_sync[1]};
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            csr_pkg::ADDR_CTRL: rd_data[csr_pkg::CTRL_EN_BIT] = global_en;
            csr_pkg::ADDR_STATUS: rd_data[csr_pkg::STATUS_READY_BIT] = sys_ready;
            default: rd_data = '0;
        endcase
    end

    // Read data loads after the header and shifts out on sck falls
    always_ff @(posedge clk) begin
        if (hdr_done) begin
            tx_shift <= header[HDR_BITS-1] ? rd_data : '0;
        end else if (tx_step) begin
            tx_shift <= {tx_shift[DATA_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spi_miso <= 1'b0;
        end else if (tx_step) begin
            spi_miso <= tx_shift[DATA_BITS-1];
        end
    end

    // Writes land on the last bit of a write frame
    // Trigger pulse sits in the third cycle after that sample
    always_ff @(posedge clk) begin
        if (rst) begin
            global_en <= 1'b0;
            trig_pipe <= '0;
            b_trigger <= 1'b0;
        end else begin
            trig_pipe <= {trig_pipe[0], 1'b0};
            b_trigger <= trig_pipe[1];
            if (frame_done && !frame[FRAME_BITS-1]) begin
                if (wr_addr == csr_pkg::ADDR_CTRL) begin
                    global_en <= wr_data[csr_pkg::CTRL_EN_BIT];
                end else if (wr_addr == csr_pkg::ADDR_TRIGGER) begin
                    trig_pipe[0] <= 1'b1;
                end
            end
        end
    end

    a_trigger_single: assert property (@(posedge clk) disable iff (rst)
        b_trigger |=> !b_trigger);

    // Host samples miso on the rising edge, so no change while the sck pin is high
    a_miso_stable: assert property (@(posedge clk) disable iff (rst)
        (spi_sck && $past(spi_sck)) |-> $stable(spi_miso));

endmodule

//--- csr_pkg.sv
`include "caster_settings.svh"

package csr_pkg;

    // Register address and data as carried in one SPI frame
    typedef logic [`CASTER_SPI_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`CASTER_SPI_DATA_BITS-1:0] reg_data_t;

    // Register map
    localparam reg_addr_t ADDR_CTRL    = 'h0;
    localparam reg_addr_t ADDR_TRIGGER = 'h1;
    localparam reg_addr_t ADDR_STATUS  = 'h2;

    // CTRL fields
    localparam int CTRL_EN_BIT = 0;

    // STATUS fields, read only
    localparam int STATUS_READY_BIT = 0;

endpackage

//--- epd_pkg.sv
`include "caster_settings.svh"

package epd_pkg;

    // One pixel's grey level
    typedef logic [`CASTER_PIX_BITS-1:0] grey_t;

    // Four grey levels, pixel 0 in the low nibble
    // Used for both target words and state words
    typedef logic [`CASTER_WORD_BITS-1:0] pix_word_t;

    // Drive code of one pixel
    typedef logic [`CASTER_DRIVE_BITS-1:0] drive_t;

    // Four drive codes, same pixel order as pix_word_t
    typedef logic [`CASTER_DRIVE_WORD_BITS-1:0] drive_word_t;

    // Drive code values seen by the source driver
    localparam drive_t DRIVE_NONE    = 2'd0;
    localparam drive_t DRIVE_DARKEN  = 2'd1;
    localparam drive_t DRIVE_LIGHTEN = 2'd2;

endpackage

//--- caster_settings.svh
`ifndef CASTER_SETTINGS_SVH
`define CASTER_SETTINGS_SVH

// Pixel format of both streams
`define CASTER_PIX_BITS 4
`define CASTER_PIX_PER_WORD 4
`define CASTER_WORD_BITS (`CASTER_PIX_BITS * `CASTER_PIX_PER_WORD)

// Drive code per pixel toward the source driver
`define CASTER_DRIVE_BITS 2
`define CASTER_DRIVE_WORD_BITS (`CASTER_DRIVE_BITS * `CASTER_PIX_PER_WORD)

// Source line length in stream words
`define CASTER_LINE_WORDS 4

// SPI frame is read flag, address, data, MSB first
`define CASTER_SPI_ADDR_BITS 7
`define CASTER_SPI_DATA_BITS 8
`define CASTER_SPI_FRAME_BITS (1 + `CASTER_SPI_ADDR_BITS + `CASTER_SPI_DATA_BITS)

`endif
